// File: design/video_pkg.sv
`default_nettype none

package video_pkg;

    // Line layout in pixel clocks
    localparam int H_ACTIVE = 640;
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BACK   = 48;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;  // 800

    // Frame layout in lines
    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;  // 525

    // Raster position to output pixel
    localparam int PIPE_DELAY = 2;

    typedef logic [9:0] coord_t;    // Screen coordinate
    typedef logic [7:0] color_t;    // RGB332

    // Syncs are active low
    typedef struct packed {
        coord_t x;
        coord_t y;
        logic   active;
        logic   hsync;
        logic   vsync;
    } raster_t;

endpackage

`default_nettype wire

// File: design/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    import video_pkg::*;

    typedef logic [11:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [7:0]  mem_word_addr_t;   // Word index into sprite RAM

    typedef struct packed {
        axil_addr_t awaddr;
        logic       awvalid;
        axil_data_t wdata;
        logic [3:0] wstrb;
        logic       wvalid;
        logic       bready;
        axil_addr_t araddr;
        logic       arvalid;
        logic       rready;
    } axil_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        logic [1:0] bresp;
        logic       arready;
        logic       rvalid;
        logic [1:0] rresp;
        axil_data_t rdata;
    } axil_rsp_t;

    typedef enum logic [1:0] {
        POSE_IDLE   = 2'd0,
        POSE_WALK   = 2'd1,
        POSE_ATTACK = 2'd2,
        POSE_BLOCK  = 2'd3
    } pose_t;

    typedef struct packed {
        logic   enable;
        coord_t pos_x;
        coord_t pos_y;
        pose_t  pose;
        color_t bg_color;
    } sprite_cfg_t;

    localparam int SPRITE_W = 16;
    localparam int SPRITE_H = 16;

    localparam color_t TRANSPARENT = 8'hE3;  // Magenta key

    // Register map
    localparam axil_addr_t REG_CTRL  = 12'h000;  // Bit 0 enables the sprite
    localparam axil_addr_t REG_POS_X = 12'h004;
    localparam axil_addr_t REG_POS_Y = 12'h008;
    localparam axil_addr_t REG_POSE  = 12'h00C;
    localparam axil_addr_t REG_BG    = 12'h010;
    localparam axil_addr_t REG_FRAME = 12'h014;  // Read only
    localparam axil_addr_t MEM_BASE  = 12'h400;  // Window up to 0x7FF

endpackage

`default_nettype wire

// File: design/video_timing.sv
`default_nettype none

module video_timing
    import video_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    output raster_t raster,
    output logic    frame_start
);

    coord_t h_cnt;
    coord_t v_cnt;
    logic   h_last;
    logic   v_last;
    logic   h_sync_on;
    logic   v_sync_on;

    assign h_last = (h_cnt == coord_t'(H_TOTAL - 1));
    assign v_last = (v_cnt == coord_t'(V_TOTAL - 1));

    // Sync windows sit after the front porch
    assign h_sync_on = (h_cnt >= coord_t'(H_ACTIVE + H_FRONT)) &&
                       (h_cnt <  coord_t'(H_ACTIVE + H_FRONT + H_SYNC));
    assign v_sync_on = (v_cnt >= coord_t'(V_ACTIVE + V_FRONT)) &&
                       (v_cnt <  coord_t'(V_ACTIVE + V_FRONT + V_SYNC));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
            v_cnt <= v_last ? '0 : v_cnt + 1'b1;  // Wrap at end of frame
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // Everything leaves through flops so the raster has no glitches
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            raster.x      <= '0;
            raster.y      <= '0;
            raster.active <= 1'b0;
            raster.hsync  <= 1'b1;  // Inactive high
            raster.vsync  <= 1'b1;
            frame_start   <= 1'b0;
        end else begin
            raster.x      <= h_cnt;
            raster.y      <= v_cnt;
            raster.active <= (h_cnt < coord_t'(H_ACTIVE)) && (v_cnt < coord_t'(V_ACTIVE));
            raster.hsync  <= ~h_sync_on;
            raster.vsync  <= ~v_sync_on;
            // First pixel of vertical blanking
            frame_start   <= (h_cnt == '0) && (v_cnt == coord_t'(V_ACTIVE));
        end
    end

endmodule

`default_nettype wire

// File: design/ctrl_regs.sv
`default_nettype none

module ctrl_regs
    import video_pkg::*;
    import ctrl_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  axil_req_t      axil_req,
    output axil_rsp_t      axil_rsp,
    input  logic           frame_start,
    output sprite_cfg_t    cfg,
    output logic           mem_we,
    output mem_word_addr_t mem_waddr,
    output logic [31:0]    mem_wdata,
    output logic [3:0]     mem_wstrb
);

    typedef enum logic {
        W_IDLE,
        W_RESP
    } wr_state_t;

    typedef enum logic {
        R_IDLE,
        R_RESP
    } rd_state_t;

    wr_state_t   wr_state;
    rd_state_t   rd_state;
    logic        wr_hs;
    logic        rd_hs;
    axil_addr_t  wr_addr;
    axil_data_t  wr_data;
    axil_data_t  rd_value;
    axil_data_t  rd_data;
    axil_data_t  frame_cnt;
    sprite_cfg_t live;

    // Address and data are taken together only
    assign wr_hs = (wr_state == W_IDLE) && axil_req.awvalid && axil_req.wvalid;
    assign rd_hs = (rd_state == R_IDLE) && axil_req.arvalid;

    assign axil_rsp.awready = wr_hs;
    assign axil_rsp.wready  = wr_hs;
    assign axil_rsp.bvalid  = (wr_state == W_RESP);
    assign axil_rsp.bresp   = 2'b00;  // OKAY
    assign axil_rsp.arready = rd_hs;
    assign axil_rsp.rvalid  = (rd_state == R_RESP);
    assign axil_rsp.rresp   = 2'b00;
    assign axil_rsp.rdata   = rd_data;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_state <= W_IDLE;
        end else if (wr_hs) begin
            wr_state <= W_RESP;
        end else if ((wr_state == W_RESP) && axil_req.bready) begin
            wr_state <= W_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            wr_addr <= axil_req.awaddr;
            wr_data <= axil_req.wdata;
        end
    end

    // Sprite window goes straight to the RAM
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_we <= 1'b0;
        end else begin
            mem_we <= wr_hs && (axil_req.awaddr[11:10] == MEM_BASE[11:10]);
        end
    end

    always_ff @(posedge clk) begin
        mem_waddr <= axil_req.awaddr[9:2];
        mem_wdata <= axil_req.wdata;
        mem_wstrb <= axil_req.wstrb;
    end

    // Live registers change when the response completes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            live <= '0;
        end else if ((wr_state == W_RESP) && axil_req.bready) begin
            case (wr_addr)
                REG_CTRL:  live.enable   <= wr_data[0];
                REG_POS_X: live.pos_x    <= wr_data[9:0];
                REG_POS_Y: live.pos_y    <= wr_data[9:0];
                REG_POSE:  live.pose     <= pose_t'(wr_data[1:0]);
                REG_BG:    live.bg_color <= wr_data[7:0];
                default:   ;  // Unmapped writes dropped
            endcase
        end
    end

    // Shadow copy only moves at the top of blanking
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg       <= '0;
            frame_cnt <= '0;
        end else if (frame_start) begin
            cfg       <= live;
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

    always_comb begin
        rd_value = '0;
        case (axil_req.araddr)
            REG_CTRL:  rd_value[0]   = live.enable;
            REG_POS_X: rd_value[9:0] = live.pos_x;
            REG_POS_Y: rd_value[9:0] = live.pos_y;
            REG_POSE:  rd_value[1:0] = live.pose;
            REG_BG:    rd_value[7:0] = live.bg_color;
            REG_FRAME: rd_value      = frame_cnt;
            default:   rd_value      = '0;  // Window and holes read zero
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_state <= R_IDLE;
            rd_data  <= '0;
        end else if (rd_hs) begin
            rd_state <= R_RESP;
            rd_data  <= rd_value;
        end else if ((rd_state == R_RESP) && axil_req.rready) begin
            rd_state <= R_IDLE;
        end
    end

endmodule

`default_nettype wire

// File: design/sprite_mem.sv
`default_nettype none

module sprite_mem
    import ctrl_pkg::*;
(
    input  logic           clk,
    input  logic           we,
    input  mem_word_addr_t waddr,
    input  logic [31:0]    wdata,
    input  logic [3:0]     wstrb,
    input  mem_word_addr_t raddr,
    output logic [31:0]    rdata
);

    // Four poses of 16 rows by 4 words
    logic [3:0][7:0] mem [2**$bits(mem_word_addr_t)];

    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < 4; i++) begin
                if (wstrb[i]) begin
                    mem[waddr][i] <= wdata[8*i +: 8];  // Byte lanes
                end
            end
        end
    end

    // Registered read keeps this in block RAM
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

// File: design/sprite_fetch.sv
`default_nettype none

module sprite_fetch
    import video_pkg::*;
    import ctrl_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  raster_t        raster,
    input  sprite_cfg_t    cfg,
    output mem_word_addr_t mem_raddr,
    input  logic [31:0]    mem_rdata,
    output color_t         rgb,
    output logic           de,
    output logic           hsync,
    output logic           vsync
);

    coord_t                rel_x;
    coord_t                rel_y;
    logic                  in_x;
    logic                  in_y;
    logic                  hit;
    logic                  hit_q;
    logic [1:0]            lane_q;
    logic [PIPE_DELAY-1:0] de_pipe;
    logic [PIPE_DELAY-1:0] hs_pipe;
    logic [PIPE_DELAY-1:0] vs_pipe;
    color_t                pixel;

    assign rel_x = raster.x - cfg.pos_x;
    assign rel_y = raster.y - cfg.pos_y;

    // Lower bound first, so the difference never wraps
    assign in_x = (raster.x >= cfg.pos_x) && (rel_x < coord_t'(SPRITE_W));
    assign in_y = (raster.y >= cfg.pos_y) && (rel_y < coord_t'(SPRITE_H));
    assign hit  = raster.active && cfg.enable && in_x && in_y;

    // pose*64 + row*4 + col/4
    assign mem_raddr = {cfg.pose, rel_y[3:0], rel_x[3:2]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hit_q  <= 1'b0;
            lane_q <= '0;
        end else begin
            hit_q  <= hit;
            lane_q <= rel_x[1:0];  // Byte within the word
        end
    end

    // Timing signals ride alongside the pixel
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            de_pipe <= '0;
            hs_pipe <= '1;
            vs_pipe <= '1;
        end else begin
            de_pipe <= {de_pipe[PIPE_DELAY-2:0], raster.active};
            hs_pipe <= {hs_pipe[PIPE_DELAY-2:0], raster.hsync};
            vs_pipe <= {vs_pipe[PIPE_DELAY-2:0], raster.vsync};
        end
    end

    assign pixel = mem_rdata[8*lane_q +: 8];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rgb <= '0;
        end else if (!de_pipe[0]) begin
            rgb <= '0;  // Blank outside active video
        end else if (hit_q && (pixel != TRANSPARENT)) begin
            rgb <= pixel;
        end else begin
            rgb <= cfg.bg_color;
        end
    end

    assign de    = de_pipe[PIPE_DELAY-1];
    assign hsync = hs_pipe[PIPE_DELAY-1];
    assign vsync = vs_pipe[PIPE_DELAY-1];

endmodule

`default_nettype wire

// File: design/sprite_renderer_top.sv
`default_nettype none

module sprite_renderer_top
    import video_pkg::*;
    import ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  axil_req_t axil_req,
    output axil_rsp_t axil_rsp,
    output color_t    rgb,
    output logic      de,
    output logic      hsync,
    output logic      vsync
);

    raster_t        raster;
    logic           frame_start;
    sprite_cfg_t    cfg;
    logic           mem_we;
    mem_word_addr_t mem_waddr;
    logic [31:0]    mem_wdata;
    logic [3:0]     mem_wstrb;
    mem_word_addr_t mem_raddr;
    logic [31:0]    mem_rdata;

    video_timing video_timing_inst (
        .clk         (clk),
        .rst         (rst),
        .raster      (raster),
        .frame_start (frame_start)
    );

    ctrl_regs ctrl_regs_inst (
        .clk         (clk),
        .rst         (rst),
        .axil_req    (axil_req),
        .axil_rsp    (axil_rsp),
        .frame_start (frame_start),
        .cfg         (cfg),
        .mem_we      (mem_we),
        .mem_waddr   (mem_waddr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb)
    );

    // Host writes on one port, pixel reads on the other
    sprite_mem sprite_mem_inst (
        .clk   (clk),
        .we    (mem_we),
        .waddr (mem_waddr),
        .wdata (mem_wdata),
        .wstrb (mem_wstrb),
        .raddr (mem_raddr),
        .rdata (mem_rdata)
    );

    sprite_fetch sprite_fetch_inst (
        .clk       (clk),
        .rst       (rst),
        .raster    (raster),
        .cfg       (cfg),
        .mem_raddr (mem_raddr),
        .mem_rdata (mem_rdata),
        .rgb       (rgb),
        .de        (de),
        .hsync     (hsync),
        .vsync     (vsync)
    );

endmodule

`default_nettype wire

// File: test/sprite_renderer_tb.sv
`default_nettype none

module sprite_renderer_tb
    import video_pkg::*;
    import ctrl_pkg::*;
;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int     LINE_CYCLES    = 800;
    localparam int     FRAME_CYCLES   = 800 * 525;
    localparam int     TIMEOUT_CYCLES = 4 * FRAME_CYCLES + 10000;
    localparam color_t KEY_COLOR      = 8'hE3;  // Transparent key

    logic      clk;
    logic      rst;
    axil_req_t req;
    axil_rsp_t rsp;
    color_t    rgb;
    logic      de;
    logic      hsync;
    logic      vsync;

    logic [15:0] lfsr;
    color_t      bitmap [1024];  // pose*256 + row*16 + col
    logic        live_en;
    logic [9:0]  live_x;
    logic [9:0]  live_y;
    logic [1:0]  live_pose;
    color_t      live_bg;
    logic        shown_en;  // Copy the screen is drawn with
    logic [9:0]  shown_x;
    logic [9:0]  shown_y;
    logic [1:0]  shown_pose;
    color_t      shown_bg;

    int     cyc;
    int     timeout_cnt;
    int     col;
    int     line_no;
    int     frames_seen;
    int     last_hs;
    int     last_vs;
    logic   hs_seen;
    logic   vs_seen;
    logic   de_q;
    logic   hs_q;
    logic   vs_q;
    color_t expected;
    int     pixels_checked;
    int     reads_checked;
    int     mismatches;
    int     errors;

    sprite_renderer_top sprite_renderer_top_inst (
        .clk      (clk),
        .rst      (rst),
        .axil_req (req),
        .axil_rsp (rsp),
        .rgb      (rgb),
        .de       (de),
        .hsync    (hsync),
        .vsync    (vsync)
    );

    always #2 clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        logic [31:0] r;
        logic        done;
        req.awaddr  = addr;
        req.awvalid = 1'b1;
        req.wdata   = data;
        req.wstrb   = strb;
        req.wvalid  = 1'b1;
        @(negedge clk);
        while (!(rsp.awready && rsp.wready)) @(negedge clk);
        @(posedge clk);
        #1;
        req.awvalid = 1'b0;
        req.wvalid  = 1'b0;
        done        = 1'b0;
        while (!done) begin
            take_bits(1, r);
            req.bready = r[0];  // Random stall
            @(negedge clk);
            done = rsp.bvalid && req.bready;
            if (done) begin
                assert (rsp.bresp == 2'b00) else begin
                    errors++;
                    $display("Write to %h got an error response", addr);
                end
            end
            @(posedge clk);
            #1;
        end
        req.bready = 1'b0;
    endtask

    task automatic axil_read(input logic [11:0] addr, output logic [31:0] data);
        logic [31:0] r;
        logic        done;
        req.araddr  = addr;
        req.arvalid = 1'b1;
        @(negedge clk);
        while (!rsp.arready) @(negedge clk);
        @(posedge clk);
        #1;
        req.arvalid = 1'b0;
        done        = 1'b0;
        while (!done) begin
            take_bits(1, r);
            req.rready = r[0];
            @(negedge clk);
            done = rsp.rvalid && req.rready;
            if (done) begin
                data = rsp.rdata;
                assert (rsp.rresp == 2'b00) else begin
                    errors++;
                    $display("Read of %h got an error response", addr);
                end
            end
            @(posedge clk);
            #1;
        end
        req.rready = 1'b0;
    endtask

    task automatic check_read(input logic [11:0] addr, input logic [31:0] exp);
        logic [31:0] got;
        axil_read(addr, got);
        reads_checked++;
        assert (got == exp) else begin
            mismatches++;
            $display("mismatch at %0t: read of %h returned %h, expected %h",
                     $time, addr, got, exp);
        end
    endtask

    // Write, update the model's live copy, read back
    task automatic set_reg(input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] exp;
        axil_write(addr, data, 4'hF);
        exp = '0;
        case (addr)
            REG_CTRL: begin
                live_en = data[0];
                exp[0]  = data[0];
            end
            REG_POS_X: begin
                live_x     = data[9:0];
                exp[9:0]   = data[9:0];
            end
            REG_POS_Y: begin
                live_y     = data[9:0];
                exp[9:0]   = data[9:0];
            end
            REG_POSE: begin
                live_pose  = data[1:0];
                exp[1:0]   = data[1:0];
            end
            REG_BG: begin
                live_bg    = data[7:0];
                exp[7:0]   = data[7:0];
            end
            default: ;
        endcase
        check_read(addr, exp);
    endtask

    task automatic load_bitmaps();
        logic [31:0] word;
        logic [31:0] r;
        for (int w = 0; w < 256; w++) begin
            for (int b = 0; b < 4; b++) begin
                take_bits(10, r);
                bitmap[w*4 + b] = (r[9:8] == 2'b00) ? KEY_COLOR : color_t'(r[7:0]);
                word[8*b +: 8]  = bitmap[w*4 + b];
            end
            axil_write(MEM_BASE + 12'(w*4), word, 4'hF);
        end
        // Lanes 0 and 2 only, walk pose row 0
        take_bits(32, r);
        axil_write(MEM_BASE + 12'(64*4), r, 4'b0101);
        bitmap[256] = r[7:0];
        bitmap[258] = r[23:16];
    endtask

    task automatic wait_for_line(input int frame, input int line);
        @(negedge clk);
        while (frames_seen < frame || (frames_seen == frame && line_no < line)) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    function automatic color_t ref_pixel(input int x, input int y);
        int rx;
        int ry;
        rx = x - int'(shown_x);
        ry = y - int'(shown_y);
        if (shown_en && rx >= 0 && rx < 16 && ry >= 0 && ry < 16) begin
            if (bitmap[int'(shown_pose)*256 + ry*16 + rx] != KEY_COLOR) begin
                return bitmap[int'(shown_pose)*256 + ry*16 + rx];
            end
        end
        return shown_bg;
    endfunction

    // Screen model rebuilt from de runs
    always @(posedge clk) begin
        if (rst) begin
            cyc         = 0;
            col         = 0;
            line_no     = 0;
            frames_seen = 0;
            hs_seen     = 1'b0;
            vs_seen     = 1'b0;
            de_q        = 1'b0;
            hs_q        = 1'b1;
            vs_q        = 1'b1;
        end else begin
            cyc++;
            if (de) begin
                expected = ref_pixel(col, line_no);
                pixels_checked++;
                assert (rgb == expected) else begin
                    mismatches++;
                    $display("mismatch at %0t: pixel (%0d,%0d) frame %0d is %h, expected %h",
                             $time, col, line_no, frames_seen, rgb, expected);
                end
                col++;
            end
            if (de_q && !de) begin
                assert (col == 640) else begin
                    errors++;
                    $display("Line %0d had %0d active pixels instead of 640", line_no, col);
                end
                col = 0;
                line_no++;
            end
            if (hs_q && !hsync) begin
                if (hs_seen) begin
                    assert (cyc - last_hs == LINE_CYCLES) else begin
                        errors++;
                        $display("Line period was %0d cycles instead of 800", cyc - last_hs);
                    end
                end
                last_hs = cyc;
                hs_seen = 1'b1;
            end
            if (!hs_q && hsync && hs_seen) begin
                assert (cyc - last_hs == 96) else begin
                    errors++;
                    $display("hsync was low for %0d cycles instead of 96", cyc - last_hs);
                end
            end
            if (vs_q && !vsync) begin
                assert (line_no == 480) else begin
                    errors++;
                    $display("Frame had %0d active lines instead of 480", line_no);
                end
                if (vs_seen) begin
                    assert (cyc - last_vs == FRAME_CYCLES) else begin
                        errors++;
                        $display("Frame period was %0d cycles", cyc - last_vs);
                    end
                end
                last_vs     = cyc;
                vs_seen     = 1'b1;
                frames_seen++;
                line_no     = 0;
                shown_en    = live_en;  // New frame takes the live registers
                shown_x     = live_x;
                shown_y     = live_y;
                shown_pose  = live_pose;
                shown_bg    = live_bg;
            end
            if (!vs_q && vsync && vs_seen) begin
                assert (cyc - last_vs == 2 * LINE_CYCLES) else begin
                    errors++;
                    $display("vsync was low for %0d cycles instead of 2 lines", cyc - last_vs);
                end
            end
            de_q = de;
            hs_q = hsync;
            vs_q = vsync;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !de |-> (rgb == 8'h00))
        else begin
            mismatches++;
            $display("mismatch at %0t: rgb is %h while de is low", $time, rgb);
        end

    assert property (@(posedge clk) disable iff (rst) de |-> (hsync && vsync))
        else begin
            errors++;
            $display("de was high during a sync pulse at %0t", $time);
        end

    always @(posedge clk) begin
        timeout_cnt++;
        if (timeout_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        req            = '0;
        lfsr           = 16'd45245;
        timeout_cnt    = 0;
        pixels_checked = 0;
        reads_checked  = 0;
        mismatches     = 0;
        errors         = 0;
        {live_en, live_x, live_y, live_pose, live_bg}       = '0;
        {shown_en, shown_x, shown_y, shown_pose, shown_bg}  = '0;

        repeat (2) @(negedge clk);
        assert (hsync && vsync && !de && rgb == 8'h00 && !rsp.bvalid && !rsp.rvalid &&
                !rsp.awready && !rsp.wready && !rsp.arready) else begin
            mismatches++;
            $display("mismatch at %0t: outputs differ from their reset values", $time);
        end
        @(posedge clk);
        #1;
        rst = 1'b0;

        check_read(REG_CTRL, 0);
        check_read(REG_POS_X, 0);
        check_read(REG_POS_Y, 0);
        check_read(REG_POSE, 0);
        check_read(REG_BG, 0);
        check_read(REG_FRAME, 0);

        load_bitmaps();
        axil_write(12'h020, 32'hFFFF_FFFF, 4'hF);  // Unmapped
        check_read(12'h020, 0);
        check_read(MEM_BASE, 0);

        // Frame 1 shows only the background
        set_reg(REG_BG, 32'h25);
        set_reg(REG_POS_X, 100);
        set_reg(REG_POS_Y, 200);
        set_reg(REG_POSE, 32'(POSE_WALK));
        set_reg(REG_CTRL, 32'h2);

        wait_for_line(1, 10);
        check_read(REG_FRAME, 1);
        set_reg(REG_CTRL, 1);

        // Sprite sits lower on screen than this point of frame 2
        wait_for_line(2, 100);
        check_read(REG_FRAME, 2);
        set_reg(REG_POS_X, 630);
        set_reg(REG_POS_Y, 472);
        set_reg(REG_POSE, 32'(POSE_BLOCK));
        set_reg(REG_BG, 32'h1C);

        wait_for_line(3, 10);
        check_read(REG_FRAME, 3);

        wait_for_line(4, 0);
        check_read(REG_FRAME, 4);

        $display("Pixels checked %0d, reads checked %0d, mismatches %0d, other errors %0d",
                 pixels_checked, reads_checked, mismatches, errors);
        if (mismatches == 0 && errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
design/video_pkg.sv
design/ctrl_pkg.sv
design/video_timing.sv
design/ctrl_regs.sv
design/sprite_mem.sv
design/sprite_fetch.sv
design/sprite_renderer_top.sv
test/sprite_renderer_tb.sv

// File: Bender.yml
package:
  name: sprite_renderer

sources:
  - target: any(design, test)
    files:
      - design/video_pkg.sv
      - design/ctrl_pkg.sv
      - design/video_timing.sv
      - design/ctrl_regs.sv
      - design/sprite_mem.sv
      - design/sprite_fetch.sv
      - design/sprite_renderer_top.sv
  - target: test
    files:
      - test/sprite_renderer_tb.sv
